// ==== calc_top.f ====
verilog/calc_pkg.sv
verilog/keypad_scanner.sv
verilog/calc_control.sv
verilog/calc_alu.sv
verilog/calc_top.sv
tests/calc_asserts.sv
tests/tb_calc_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the keypad calculator testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert \
    -f calc_top.f --top-module tb_calc_top \
    --Mdir "$OBJ" -o sim_calc
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/sim_calc" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

grep -q "^TESTBENCH PASSED$" "$LOG" || exit 1
exit 0

// ==== tests/tb_calc_top.sv ====
`timescale 1ns/1ps

module tb_calc_top
    import calc_pkg::*;
();

    localparam int       CLK_PERIOD    = 8;
    localparam int       HOLD_CYCLES   = DEBOUNCE_CYCLES + 12;  // normal press length
    localparam int       IDLE_CYCLES   = 8;                     // gap after each release
    localparam int       LONG_HOLD     = 200;
    localparam int       BOUNCE_HOLD   = DEBOUNCE_CYCLES - 3;   // too short to confirm
    localparam int       RESULT_WAIT   = 40;                    // cycles after release
    localparam int       NUM_CALCS     = 40;
    localparam int       NUM_FREE      = 60;                    // fully random keys
    localparam int       MAX_KEYS      = 20 + NUM_CALCS * 14 + NUM_FREE;
    localparam int       WATCHDOG_NS   = (MAX_KEYS * 60 + LONG_HOLD + 500) * CLK_PERIOD;
    localparam key_pos_t POS_ADD       = 4'd3;
    localparam key_pos_t POS_SUB       = 4'd7;
    localparam key_pos_t POS_MUL       = 4'd11;
    localparam key_pos_t POS_EQ        = 4'd12;
    localparam key_pos_t POS_NEG       = 4'd15;

    logic       clk;
    logic       nRST;
    logic [3:0] row_in;
    logic [3:0] col_out;
    result_t    result;
    logic       result_valid;
    operand_t   entry;
    logic       held;          // key is down
    key_pos_t   held_pos;      // which key is down
    integer     seed;
    int         errors;
    int         checks;
    int         result_count;  // strobes seen since reset
    result_t    last_result;
    int         m_mag;         // model entry magnitude
    bit         m_neg;         // model entry sign
    int         m_cnt;         // model digit count
    bit         m_op_valid;
    alu_op_e    m_op;
    int         m_acc;         // model left operand
    int         exp_result;

    calc_top i_calc_top (
        .clk          (clk),
        .nRST         (nRST),
        .row_in       (row_in),
        .col_out      (col_out),
        .result       (result),
        .result_valid (result_valid),
        .entry        (entry)
    );

    bind calc_top calc_asserts i_calc_asserts (
        .clk          (clk),
        .nRST         (nRST),
        .row_in       (row_in),
        .col_out      (col_out),
        .key_req      (key_req),
        .key_ack      (key_ack),
        .key_event    (key_event),
        .result_valid (result_valid)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // matrix: row pulled low only while its key's column is driven
    always_comb begin
        row_in = 4'b1111;
        if (held && !col_out[held_pos[1:0]]) begin
            row_in[held_pos[3:2]] = 1'b0;
        end
    end

    always @(posedge clk) begin
        if (!nRST) begin
            result_count <= 0;
        end else if (result_valid) begin
            result_count <= result_count + 1;
            last_result  <= result;   // registered in dut, stable here
        end
    end

    function automatic key_event_t key_decode(input key_pos_t pos);
        key_event_t ev;
        ev.digit = 4'd0;
        case (pos)
            4'd3:    ev.kind = KEY_ADD;
            4'd7:    ev.kind = KEY_SUB;
            4'd11:   ev.kind = KEY_MUL;
            4'd12:   ev.kind = KEY_EQUAL;
            4'd13:   ev.kind = KEY_DIGIT;   // zero
            4'd14:   ev.kind = KEY_NONE;
            4'd15:   ev.kind = KEY_NEG;
            default: begin
                ev.kind  = KEY_DIGIT;
                ev.digit = digit_t'(pos - (pos >> 2) + 1);  // three digits per row
            end
        endcase
        return ev;
    endfunction

    function automatic key_pos_t digit_pos(input int d);
        if (d == 0) begin
            return 4'd13;
        end
        return key_pos_t'(((d - 1) / 3) * 4 + (d - 1) % 3);
    endfunction

    function automatic key_pos_t op_pos(input int k);
        if (k == 0) begin
            return POS_ADD;
        end else if (k == 1) begin
            return POS_SUB;
        end
        return POS_MUL;
    endfunction

    function automatic int model_entry();
        return m_neg ? -m_mag : m_mag;
    endfunction

    // calculator rules applied to one event
    task automatic apply_model(input key_event_t ev);
        case (ev.kind)
            KEY_DIGIT: begin
                if (m_cnt < MAX_DIGITS) begin
                    m_mag = m_mag * 10 + int'(ev.digit);
                    m_cnt = m_cnt + 1;
                end
            end
            KEY_NEG: begin
                m_neg = !m_neg;
            end
            KEY_ADD, KEY_SUB, KEY_MUL: begin
                if (!(m_op_valid && m_cnt == 0)) begin  // repeat keeps the entry
                    m_acc = model_entry();
                    m_mag = 0;
                    m_neg = 1'b0;
                    m_cnt = 0;
                end
                m_op_valid = 1'b1;
                m_op = (ev.kind == KEY_ADD) ? OP_ADD : (ev.kind == KEY_SUB) ? OP_SUB : OP_MUL;
            end
            KEY_EQUAL: begin
                if (!m_op_valid) begin
                    exp_result = model_entry();         // 0 + entry
                end else if (m_op == OP_ADD) begin
                    exp_result = m_acc + model_entry();
                end else if (m_op == OP_SUB) begin
                    exp_result = m_acc - model_entry();
                end else begin
                    exp_result = m_acc * model_entry();
                end
                m_mag      = 0;
                m_neg      = 1'b0;
                m_cnt      = 0;
                m_op_valid = 1'b0;
            end
            default: begin
            end
        endcase
    endtask

    task automatic check_entry(input key_pos_t pos);
        checks++;
        if (entry !== operand_t'(model_entry())) begin
            errors++;
            $display("mismatch at %0t: entry %0d after key %0d, expected %0d",
                     $time, entry, pos, model_entry());
        end
    endtask

    // hold a key on the matrix, release, then idle
    task automatic drive_key(input key_pos_t pos, input int hold);
        @(posedge clk);
        held     <= 1'b1;
        held_pos <= pos;
        repeat (hold) @(posedge clk);
        held <= 1'b0;
        repeat (IDLE_CYCLES) @(posedge clk);
    endtask

    task automatic press_key(input key_pos_t pos, input int hold);
        key_event_t ev;
        int         count_before;
        int         waited;
        ev           = key_decode(pos);
        count_before = result_count;
        drive_key(pos, hold);
        apply_model(ev);
        if (ev.kind == KEY_EQUAL) begin
            waited = IDLE_CYCLES;
            while (result_count == count_before && waited < RESULT_WAIT) begin
                @(posedge clk);
                waited++;
            end
            checks++;
            if (result_count == count_before) begin
                errors++;
                $display("no result_valid within %0d cycles of releasing equals", RESULT_WAIT);
            end else if (result_count != count_before + 1) begin
                errors++;
                $display("equals gave %0d result strobes instead of one",
                         result_count - count_before);
            end else if (last_result !== result_t'(exp_result)) begin
                errors++;
                $display("mismatch at %0t: result %0d, expected %0d",
                         $time, last_result, exp_result);
            end
        end else if (result_count != count_before) begin
            errors++;
            $display("result_valid pulsed after key %0d, which is not equals", pos);
        end
        check_entry(pos);
    endtask

    // random operand, up to five digits and maybe negated
    task automatic enter_number();
        int ndig;
        int i;
        ndig = 1 + ($unsigned($random(seed)) % 5);  // five hits the digit limit
        for (i = 0; i < ndig; i++) begin
            press_key(digit_pos($unsigned($random(seed)) % 10), HOLD_CYCLES);
        end
        if ($random(seed) & 1) begin
            press_key(POS_NEG, HOLD_CYCLES);
        end
    endtask

    initial begin
        int       c;
        nRST       <= 1'b0;
        held       <= 1'b0;
        held_pos   <= '0;
        seed       = 24;
        errors     = 0;
        checks     = 0;
        m_mag      = 0;
        m_neg      = 1'b0;
        m_cnt      = 0;
        m_op_valid = 1'b0;
        m_op       = OP_ADD;
        m_acc      = 0;
        exp_result = 0;
        repeat (5) @(posedge clk);
        nRST <= 1'b1;
        @(posedge clk);
        check_entry(4'd0);                        // entry 0 out of reset

        press_key(digit_pos(7), LONG_HOLD);       // one event despite long hold
        drive_key(digit_pos(3), BOUNCE_HOLD);     // bounce, no event
        check_entry(digit_pos(3));                // model untouched, entry must hold
        for (c = 1; c <= 5; c++) begin
            press_key(digit_pos(c), HOLD_CYCLES); // 4 and 5 dropped at the limit
        end
        repeat (3) press_key(POS_NEG, HOLD_CYCLES);
        press_key(POS_ADD, HOLD_CYCLES);
        press_key(POS_SUB, HOLD_CYCLES);
        press_key(POS_MUL, HOLD_CYCLES);          // only mul kept
        press_key(digit_pos(2), HOLD_CYCLES);
        press_key(POS_EQ, HOLD_CYCLES);
        press_key(digit_pos(4), HOLD_CYCLES);
        press_key(digit_pos(2), HOLD_CYCLES);
        press_key(POS_EQ, HOLD_CYCLES);           // no operator, gives entry

        for (c = 0; c < NUM_CALCS; c++) begin
            enter_number();
            press_key(op_pos($unsigned($random(seed)) % 3), HOLD_CYCLES);
            enter_number();
            press_key(POS_EQ, HOLD_CYCLES);
        end
        for (c = 0; c < NUM_FREE; c++) begin
            press_key(key_pos_t'($unsigned($random(seed)) % 16), HOLD_CYCLES);
        end

        $display("errors=%0d checks=%0d", errors, checks);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("errors=%0d checks=%0d", errors, checks);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== tests/calc_asserts.sv ====
`timescale 1ns/1ps

module calc_asserts
    import calc_pkg::*;
(
    input logic       clk,
    input logic       nRST,
    input logic [3:0] row_in,        // active low rows
    input logic [3:0] col_out,       // one column low at a time
    input logic       key_req,
    input logic       key_ack,
    input key_event_t key_event,
    input logic       result_valid
);

    // scan stops on the driven column while a row is low
    col_held: assert property (@(posedge clk) disable iff (!nRST)
        !(&row_in) |=> $stable(col_out))
        else $error("col_out moved while a row was low");

    // event held while waiting for ack
    event_stable: assert property (@(posedge clk) disable iff (!nRST)
        (key_req && !key_ack) |=> $stable(key_event))
        else $error("key_event changed before key_ack");

    ack_follows_req: assert property (@(posedge clk) disable iff (!nRST)
        $rose(key_req) |=> key_ack)
        else $error("key_ack did not follow key_req within one cycle");

    ack_needs_req: assert property (@(posedge clk) disable iff (!nRST)
        key_ack |-> key_req)
        else $error("key_ack without key_req");

    // strobe lasts one cycle
    valid_single: assert property (@(posedge clk) disable iff (!nRST)
        result_valid |=> !result_valid)
        else $error("result_valid high two cycles in a row");

endmodule

// ==== verilog/calc_top.sv ====
`timescale 1ns/1ps

module calc_top
    import calc_pkg::*;
(
    input  logic       clk,
    input  logic       nRST,
    input  logic [3:0] row_in,        // keypad rows, active low
    output logic [3:0] col_out,       // keypad columns, one low
    output result_t    result,
    output logic       result_valid,  // one-cycle strobe
    output operand_t   entry          // current entry with sign
);

    logic       key_req;    // scanner to controller
    key_event_t key_event;
    logic       key_ack;    // controller to scanner
    logic       alu_start;  // controller to alu
    alu_op_e    alu_op;
    operand_t   operand_a;
    operand_t   operand_b;

    keypad_scanner i_keypad_scanner (
        .clk       (clk),
        .nRST      (nRST),
        .row_in    (row_in),
        .col_out   (col_out),
        .key_req   (key_req),
        .key_event (key_event),
        .key_ack   (key_ack)
    );

    calc_control i_calc_control (
        .clk       (clk),
        .nRST      (nRST),
        .key_req   (key_req),
        .key_event (key_event),
        .key_ack   (key_ack),
        .alu_start (alu_start),
        .alu_op    (alu_op),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .entry     (entry)
    );

    calc_alu i_calc_alu (
        .clk          (clk),
        .nRST         (nRST),
        .alu_start    (alu_start),
        .alu_op       (alu_op),
        .operand_a    (operand_a),
        .operand_b    (operand_b),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

// ==== verilog/calc_alu.sv ====
`timescale 1ns/1ps

module calc_alu
    import calc_pkg::*;
(
    input  logic     clk,
    input  logic     nRST,
    input  logic     alu_start,     // one-cycle launch
    input  alu_op_e  alu_op,
    input  operand_t operand_a,
    input  operand_t operand_b,
    output result_t  result,        // held until next start
    output logic     result_valid   // one cycle after alu_start
);

    result_t a_ext;       // sign-extended a
    result_t b_ext;       // sign-extended b
    result_t alu_value;   // combinational result

    assign a_ext = result_t'(operand_a);  // signed source, extends sign
    assign b_ext = result_t'(operand_b);

    always_comb begin
        case (alu_op)
            OP_ADD:  alu_value = a_ext + b_ext;
            OP_SUB:  alu_value = a_ext - b_ext;
            OP_MUL:  alu_value = a_ext * b_ext;  // 9999*9999 fits in 32 bits
            default: alu_value = '0;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= alu_start;  // strobe lasts one cycle
        end
    end

    always_ff @(posedge clk) begin
        if (alu_start) begin
            result <= alu_value;
        end
    end

endmodule

// ==== verilog/calc_control.sv ====
`timescale 1ns/1ps

module calc_control
    import calc_pkg::*;
(
    input  logic       clk,
    input  logic       nRST,
    input  logic       key_req,    // scanner has an event
    input  key_event_t key_event,
    output logic       key_ack,    // pulse, cycle after key_req
    output logic       alu_start,  // pulse, same cycle as ack on equals
    output alu_op_e    alu_op,
    output operand_t   operand_a,
    output operand_t   operand_b,
    output operand_t   entry       // value being typed, signed
);

    logic       take;       // new event this cycle
    logic       is_op;      // event is add, sub or mul
    logic       op_repeat;  // operator with no digits since the last one
    operand_t   mag;        // entry magnitude
    logic       neg;        // entry sign
    digit_cnt_t digit_cnt;  // digits in current entry
    logic       op_valid;   // an operator is pending
    alu_op_e    op_q;       // pending operator
    alu_op_e    op_new;     // operator carried by this event
    operand_t   acc_q;      // left operand waiting for equals
    operand_t   mag_next;   // magnitude with the new digit appended

    assign take = key_req && !key_ack;  // ack not yet given

    assign is_op = (key_event.kind == KEY_ADD) ||
                   (key_event.kind == KEY_SUB) ||
                   (key_event.kind == KEY_MUL);

    assign op_repeat = op_valid && (digit_cnt == '0);

    always_comb begin
        case (key_event.kind)
            KEY_SUB: op_new = OP_SUB;
            KEY_MUL: op_new = OP_MUL;
            default: op_new = OP_ADD;
        endcase
    end

    assign mag_next = mag * operand_t'(10) + operand_t'(key_event.digit);

    assign entry = neg ? -mag : mag;  // sign kept apart so -0 then digits works

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            key_ack   <= 1'b0;
            alu_start <= 1'b0;
            mag       <= '0;
            neg       <= 1'b0;
            digit_cnt <= '0;
            op_valid  <= 1'b0;
        end else begin
            key_ack   <= take;
            alu_start <= take && (key_event.kind == KEY_EQUAL);

            if (take) begin
                case (key_event.kind)
                    KEY_DIGIT: begin
                        if (digit_cnt < digit_cnt_t'(MAX_DIGITS)) begin
                            mag       <= mag_next;
                            digit_cnt <= digit_cnt + 1'b1;
                        end                          // extra digits dropped
                    end
                    KEY_NEG: begin
                        neg <= !neg;
                    end
                    KEY_ADD, KEY_SUB, KEY_MUL: begin
                        if (!op_repeat) begin
                            mag       <= '0;         // entry moved to acc
                            neg       <= 1'b0;
                            digit_cnt <= '0;
                        end
                        op_valid <= 1'b1;
                    end
                    KEY_EQUAL: begin
                        mag       <= '0;
                        neg       <= 1'b0;
                        digit_cnt <= '0;
                        op_valid  <= 1'b0;           // chain ends here
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // operand and operator registers
    always_ff @(posedge clk) begin
        if (take && is_op) begin
            op_q <= op_new;                          // last operator wins
            if (!op_repeat) begin
                acc_q <= entry;
            end
        end

        if (take && key_event.kind == KEY_EQUAL) begin
            operand_b <= entry;
            if (op_valid) begin
                operand_a <= acc_q;
                alu_op    <= op_q;
            end else begin
                operand_a <= '0;                     // bare equals, 0 + entry
                alu_op    <= OP_ADD;
            end
        end
    end

endmodule

// ==== verilog/keypad_scanner.sv ====
`timescale 1ns/1ps

module keypad_scanner
    import calc_pkg::*;
(
    input  logic       clk,
    input  logic       nRST,
    input  logic [3:0] row_in,     // active low, pulled up
    output logic [3:0] col_out,    // one column low at a time
    output logic       key_req,    // event pending for controller
    output key_event_t key_event,  // held stable while key_req
    input  logic       key_ack     // one-cycle pulse from controller
);

    typedef enum logic [2:0] {
        IDLE,
        SCAN_COL,
        WAIT_STABLE,
        CONFIRM,
        WAIT_RELEASE
    } scan_state_e;

    scan_state_e state, next_state;

    logic [1:0] col_idx;    // column currently driven low
    logic [1:0] row_sel;    // lowest low row
    logic       press;      // any row low
    debounce_t  deb_cnt;    // cycles the press has held
    key_pos_t   key_pos;    // row*4 + col
    key_event_t dec_event;  // key map lookup
    logic       deb_done;   // press held long enough
    logic       launch;     // entering CONFIRM this cycle

    assign press = ~&row_in;  // rows pulled up, low means pressed

    // lowest low row wins when several keys are down
    always_comb begin
        row_sel = 2'd0;
        for (int r = 3; r >= 0; r--) begin
            if (!row_in[r]) begin
                row_sel = 2'(r);
            end
        end
    end

    assign key_pos   = {row_sel, col_idx};  // row*4 + col
    assign dec_event = KEY_MAP[key_pos];

    assign deb_done = (deb_cnt == debounce_t'(DEBOUNCE_CYCLES - 1));

    // drive exactly the selected column low
    always_comb begin
        col_out          = 4'b1111;
        col_out[col_idx] = 1'b0;
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                next_state = SCAN_COL;
            end
            SCAN_COL: begin
                if (press) begin
                    next_state = WAIT_STABLE;  // freeze column, start debounce
                end
            end
            WAIT_STABLE: begin
                if (!press) begin
                    next_state = SCAN_COL;     // bounce, back to scanning
                end else if (deb_done) begin
                    // the blank key is swallowed here
                    if (dec_event.kind == KEY_NONE) begin
                        next_state = WAIT_RELEASE;
                    end else begin
                        next_state = CONFIRM;
                    end
                end
            end
            CONFIRM: begin
                if (key_ack) begin
                    next_state = WAIT_RELEASE;
                end
            end
            WAIT_RELEASE: begin
                if (!press) begin
                    next_state = IDLE;         // all rows high again
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    assign launch = (state == WAIT_STABLE) && (next_state == CONFIRM);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state   <= IDLE;
            col_idx <= 2'd0;
            deb_cnt <= '0;
            key_req <= 1'b0;
        end else begin
            state <= next_state;

            // rotate only while nothing is seen
            if (state == SCAN_COL && !press) begin
                col_idx <= col_idx + 2'd1;
            end

            if (state == WAIT_STABLE && press) begin
                deb_cnt <= deb_cnt + 1'b1;
            end else begin
                deb_cnt <= '0;     // press vanished or not debouncing
            end

            if (launch) begin
                key_req <= 1'b1;
            end else if (state == CONFIRM && key_ack) begin
                key_req <= 1'b0;   // drop on the edge after ack
            end
        end
    end

    // position latched as the press is confirmed, held through CONFIRM
    always_ff @(posedge clk) begin
        if (launch) begin
            key_event <= dec_event;
        end
    end

endmodule

// ==== verilog/calc_pkg.sv ====
package calc_pkg;

    localparam int DIGIT_W         = 4;   // one bcd digit
    localparam int POS_W           = 4;   // row*4 + col
    localparam int OPERAND_W       = 16;  // signed entry, +/-9999
    localparam int RESULT_W        = 32;  // holds 9999*9999 with sign
    localparam int DEBOUNCE_CYCLES = 10;  // cycles a press must stay low
    localparam int MAX_DIGITS      = 4;   // digits accepted per entry

    localparam int DEBOUNCE_W  = $clog2(DEBOUNCE_CYCLES);  // counts 0..DEBOUNCE_CYCLES-1
    localparam int DIGIT_CNT_W = $clog2(MAX_DIGITS + 1);   // counts 0..MAX_DIGITS

    typedef logic        [DIGIT_W-1:0]     digit_t;
    typedef logic        [POS_W-1:0]       key_pos_t;
    typedef logic signed [OPERAND_W-1:0]   operand_t;
    typedef logic signed [RESULT_W-1:0]    result_t;
    typedef logic        [DEBOUNCE_W-1:0]  debounce_t;
    typedef logic        [DIGIT_CNT_W-1:0] digit_cnt_t;

    typedef enum logic [2:0] {
        KEY_DIGIT,
        KEY_ADD,
        KEY_SUB,
        KEY_MUL,
        KEY_EQUAL,
        KEY_NEG,
        KEY_NONE    // position 14, never reported
    } key_kind_e;

    typedef enum logic [1:0] {
        OP_ADD,
        OP_SUB,
        OP_MUL
    } alu_op_e;

    typedef struct packed {
        key_kind_e kind;   // what was pressed
        digit_t    digit;  // value, only meaningful for KEY_DIGIT
    } key_event_t;

    // indexed by key position, row major
    localparam key_event_t KEY_MAP [16] = '{
        '{KEY_DIGIT, 4'd1}, '{KEY_DIGIT, 4'd2}, '{KEY_DIGIT, 4'd3}, '{KEY_ADD,   4'd0},
        '{KEY_DIGIT, 4'd4}, '{KEY_DIGIT, 4'd5}, '{KEY_DIGIT, 4'd6}, '{KEY_SUB,   4'd0},
        '{KEY_DIGIT, 4'd7}, '{KEY_DIGIT, 4'd8}, '{KEY_DIGIT, 4'd9}, '{KEY_MUL,   4'd0},
        '{KEY_EQUAL, 4'd0}, '{KEY_DIGIT, 4'd0}, '{KEY_NONE,  4'd0}, '{KEY_NEG,   4'd0}
    };

endpackage
